//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_fdiv \
		--Mdir obj_dir -o tb_fdiv
	./obj_dir/tb_fdiv 2>&1 | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/fdiv_ctrl_pkg.sv
`default_nettype none

package fdiv_ctrl_pkg;

	typedef enum logic [1:0] {
		IDLE,
		ITERATE,
		NORMALIZE,
		DONE
	} state_t;

	localparam int QUOTIENT_WIDTH = 55;
	localparam int REMAINDER_WIDTH = 57;
	localparam int INDEX_WIDTH = 6;

	typedef logic [QUOTIENT_WIDTH-1:0] quotient_t;
	typedef logic [REMAINDER_WIDTH-1:0] remainder_t;
	typedef logic [INDEX_WIDTH-1:0] bit_index_t;

	// Bit index range of the recurrence.
	localparam bit_index_t DIV_FIRST_BIT = 6'd54;
	localparam bit_index_t SQRT_FIRST_BIT = 6'd53;
	localparam bit_index_t SINGLE_LAST_BIT = 6'd29;
	localparam bit_index_t DOUBLE_LAST_BIT = 6'd0;

	// Normalization field is quotient, remainder and zero padding, left aligned.
	localparam int FIELD_PAD = 53;
	localparam int FIELD_WIDTH = QUOTIENT_WIDTH + REMAINDER_WIDTH + FIELD_PAD;
	localparam int GUARD_SINGLE = FIELD_WIDTH - 1 - fp_format_pkg::MANT_SINGLE_BITS;
	localparam int GUARD_DOUBLE = FIELD_WIDTH - 1 - fp_format_pkg::MANT_DOUBLE_BITS;

endpackage

`default_nettype wire

//--- design/fdiv_iterator.sv
`timescale 1ns/1ps
`default_nettype none

module fdiv_iterator (
	input logic clock_i,
	input logic reset_i,
	input logic fdiv_i,
	input logic fsqrt_i,
	input logic fmt_i,
	input logic [fp_format_pkg::FRAC_WIDTH-1:0] fraction_a_i,
	input logic [fp_format_pkg::FRAC_WIDTH-1:0] fraction_b_i,
	input logic exp_a_lsb_i,
	input logic op_sqrt_i,
	output logic capture_o,
	output logic load_o,
	output logic ready_o,
	output fdiv_ctrl_pkg::quotient_t quotient_o,
	output fdiv_ctrl_pkg::remainder_t remainder_o
);

	fdiv_ctrl_pkg::state_t state_q;
	fdiv_ctrl_pkg::state_t state_d;
	fdiv_ctrl_pkg::bit_index_t index_q;
	fdiv_ctrl_pkg::bit_index_t first_bit;
	fdiv_ctrl_pkg::bit_index_t last_bit;
	logic fmt_q;
	fdiv_ctrl_pkg::quotient_t quotient_q;
	fdiv_ctrl_pkg::quotient_t quotient_d;
	fdiv_ctrl_pkg::remainder_t remainder_q;
	fdiv_ctrl_pkg::remainder_t remainder_init;
	fdiv_ctrl_pkg::remainder_t remainder_cur;
	fdiv_ctrl_pkg::remainder_t remainder_shift;
	fdiv_ctrl_pkg::remainder_t divisor;
	fdiv_ctrl_pkg::remainder_t difference;
	fdiv_ctrl_pkg::remainder_t remainder_d;

	//////////////////////////////
	// Control FSM.
	//////////////////////////////

	assign capture_o = (state_q == fdiv_ctrl_pkg::IDLE) && (fdiv_i || fsqrt_i);
	assign load_o = state_q == fdiv_ctrl_pkg::NORMALIZE;
	assign ready_o = state_q == fdiv_ctrl_pkg::DONE;

	assign first_bit = op_sqrt_i ? fdiv_ctrl_pkg::SQRT_FIRST_BIT : fdiv_ctrl_pkg::DIV_FIRST_BIT;
	assign last_bit = (fmt_q == fp_format_pkg::FMT_SINGLE) ? fdiv_ctrl_pkg::SINGLE_LAST_BIT :
		fdiv_ctrl_pkg::DOUBLE_LAST_BIT; // Single stops early.

	always_comb begin
		state_d = state_q;
		case (state_q)
			fdiv_ctrl_pkg::IDLE: begin
				if (capture_o) begin
					state_d = fdiv_ctrl_pkg::ITERATE;
				end
			end
			fdiv_ctrl_pkg::ITERATE: begin
				if (index_q == last_bit) begin
					state_d = fdiv_ctrl_pkg::NORMALIZE;
				end
			end
			fdiv_ctrl_pkg::NORMALIZE: state_d = fdiv_ctrl_pkg::DONE;
			default: state_d = fdiv_ctrl_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q <= fdiv_ctrl_pkg::IDLE;
			index_q <= '0;
		end else begin
			state_q <= state_d;
			if (capture_o) begin
				index_q <= fsqrt_i ? fdiv_ctrl_pkg::SQRT_FIRST_BIT : fdiv_ctrl_pkg::DIV_FIRST_BIT;
			end else if (state_q == fdiv_ctrl_pkg::ITERATE && index_q != last_bit) begin
				index_q <= index_q - 6'd1;
			end
		end
	end

	//////////////////////////////
	// Shift-subtract recurrence.
	//////////////////////////////

	always_comb begin
		remainder_init = {5'b00001, fraction_a_i};
		if (op_sqrt_i && !exp_a_lsb_i) begin
			remainder_init = {4'b0001, fraction_a_i, 1'b0}; // Even exponent for the root.
		end
		remainder_cur = (index_q == first_bit) ? remainder_init : remainder_q;

		if (op_sqrt_i) begin
			divisor = {1'b0, quotient_q, 1'b0};
			divisor[index_q] = 1'b1; // Trial root bit.
		end else begin
			divisor = {4'b0001, fraction_b_i, 1'b0};
		end

		remainder_shift = {remainder_cur[fdiv_ctrl_pkg::REMAINDER_WIDTH-2:0], 1'b0};
		difference = remainder_shift - divisor;
		quotient_d = quotient_q;
		remainder_d = remainder_shift;
		if (!difference[fdiv_ctrl_pkg::REMAINDER_WIDTH-1]) begin
			quotient_d[index_q] = 1'b1;
			remainder_d = difference;
		end
	end

	always_ff @(posedge clock_i) begin
		if (capture_o) begin
			fmt_q <= fmt_i;
			quotient_q <= '0;
		end else if (state_q == fdiv_ctrl_pkg::ITERATE) begin
			quotient_q <= quotient_d;
			remainder_q <= remainder_d;
		end
	end

	assign quotient_o = quotient_q;
	assign remainder_o = remainder_q;

endmodule

`default_nettype wire

//--- design/fdiv_normalizer.sv
`timescale 1ns/1ps
`default_nettype none

module fdiv_normalizer (
	input logic clock_i,
	input logic reset_i,
	input logic load_i,
	input fdiv_ctrl_pkg::quotient_t quotient_i,
	input fdiv_ctrl_pkg::remainder_t remainder_i,
	input logic sign_i,
	input fp_format_pkg::exponent_t exponent_diff_i,
	input logic fmt_i,
	output logic sign_o,
	output fp_format_pkg::exponent_t exponent_o,
	output fp_format_pkg::mantissa_t mantissa_o,
	output fp_format_pkg::grs_t grs_o
);

	logic [fdiv_ctrl_pkg::FIELD_WIDTH-1:0] field;
	fp_format_pkg::exponent_t exp_res;
	fp_format_pkg::exponent_t exp_shift;
	logic [5:0] shift_amt;
	logic rem_nonzero;
	fp_format_pkg::mantissa_t mantissa_d;
	fp_format_pkg::grs_t grs_d;

	always_comb begin
		field = {quotient_i, remainder_i, {fdiv_ctrl_pkg::FIELD_PAD{1'b0}}};
		exp_res = exponent_diff_i;
		if (!field[fdiv_ctrl_pkg::FIELD_WIDTH-1]) begin
			field = field << 1;
			exp_res = exp_res - 14'sd1;
		end

		if (fmt_i == fp_format_pkg::FMT_DOUBLE) begin
			exp_res = exp_res + fp_format_pkg::BIAS_DOUBLE;
		end else begin
			exp_res = exp_res + fp_format_pkg::BIAS_SINGLE;
		end

		//////////////////////////////
		// Underflow denormalization.
		exp_shift = '0;
		if (exp_res <= 0) begin
			exp_shift = fp_format_pkg::UNDERFLOW_SHIFT_MAX;
			if (exp_res > -fp_format_pkg::UNDERFLOW_SHIFT_MAX) begin
				exp_shift = 14'sd1 - exp_res;
			end
			exp_res = '0;
		end
		shift_amt = exp_shift[5:0];
		field = field >> shift_amt;

		// Remainder bits can fall off the bottom on a full shift.
		rem_nonzero = |remainder_i;

		if (fmt_i == fp_format_pkg::FMT_DOUBLE) begin
			mantissa_d = fp_format_pkg::mantissa_t'(
				field[fdiv_ctrl_pkg::FIELD_WIDTH-1:fdiv_ctrl_pkg::GUARD_DOUBLE+1]);
			grs_d[2] = field[fdiv_ctrl_pkg::GUARD_DOUBLE];
			grs_d[1] = field[fdiv_ctrl_pkg::GUARD_DOUBLE-1];
			grs_d[0] = (|field[fdiv_ctrl_pkg::GUARD_DOUBLE-2:0]) | rem_nonzero;
		end else begin
			mantissa_d = fp_format_pkg::mantissa_t'(
				field[fdiv_ctrl_pkg::FIELD_WIDTH-1:fdiv_ctrl_pkg::GUARD_SINGLE+1]);
			grs_d[2] = field[fdiv_ctrl_pkg::GUARD_SINGLE];
			grs_d[1] = field[fdiv_ctrl_pkg::GUARD_SINGLE-1];
			grs_d[0] = (|field[fdiv_ctrl_pkg::GUARD_SINGLE-2:0]) | rem_nonzero;
		end
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			sign_o <= 1'b0;
			exponent_o <= '0;
			mantissa_o <= '0;
			grs_o <= '0;
		end else if (load_i) begin
			sign_o <= sign_i;
			exponent_o <= exp_res;
			mantissa_o <= mantissa_d;
			grs_o <= grs_d;
		end
	end

endmodule

`default_nettype wire

//--- design/fdiv_special_cases.sv
`timescale 1ns/1ps
`default_nettype none

module fdiv_special_cases (
	input logic clock_i,
	input logic reset_i,
	input logic capture_i,
	input logic sqrt_i,
	input fp_format_pkg::operand_t data1_i,
	input fp_format_pkg::operand_t data2_i,
	input fp_format_pkg::class_t class1_i,
	input fp_format_pkg::class_t class2_i,
	input logic fmt_i,
	input fp_format_pkg::rm_t rm_i,
	output logic sign_o,
	output fp_format_pkg::exponent_t exponent_diff_o,
	output logic [fp_format_pkg::FRAC_WIDTH-1:0] fraction_a_o,
	output logic [fp_format_pkg::FRAC_WIDTH-1:0] fraction_b_o,
	output logic exp_a_lsb_o,
	output logic op_sqrt_o,
	output logic fmt_o,
	output fp_format_pkg::rm_t rm_o,
	output logic snan_o,
	output logic qnan_o,
	output logic dbz_o,
	output logic inf_o,
	output logic zero_o
);

	fp_format_pkg::operand_t op_b;
	fp_format_pkg::class_t cls_b;
	fp_format_pkg::exponent_t exp_a;
	fp_format_pkg::exponent_t exp_b;
	fp_format_pkg::exponent_t exp_diff;
	logic a_zero;
	logic a_inf;
	logic a_finite_nz;
	logic a_negative;
	logic b_zero;
	logic b_inf;
	logic b_finite_nz;
	logic snan_d;
	logic qnan_d;
	logic inf_d;
	logic dbz_d;
	logic zero_d;

	assign op_b = sqrt_i ? fp_format_pkg::SQRT_DIVISOR : data2_i;
	assign cls_b = sqrt_i ? '0 : class2_i; // No class for the fixed divisor.

	assign exp_a = {2'b00, data1_i[fp_format_pkg::FRAC_WIDTH +: fp_format_pkg::EXP_WIDTH]};
	assign exp_b = {2'b00, op_b[fp_format_pkg::FRAC_WIDTH +: fp_format_pkg::EXP_WIDTH]};

	// Root halves the unbiased exponent.
	assign exp_diff = sqrt_i ? (exp_a - fp_format_pkg::SQRT_EXP_OFFSET) >>> 1 : exp_a - exp_b;

	//////////////////////////////
	// Flags.
	//////////////////////////////

	always_comb begin
		a_zero = class1_i[fp_format_pkg::CLS_NEG_ZERO] | class1_i[fp_format_pkg::CLS_POS_ZERO];
		a_inf = class1_i[fp_format_pkg::CLS_NEG_INF] | class1_i[fp_format_pkg::CLS_POS_INF];
		a_negative = class1_i[fp_format_pkg::CLS_NEG_NORM] | class1_i[fp_format_pkg::CLS_NEG_SUB];
		a_finite_nz = a_negative | class1_i[fp_format_pkg::CLS_POS_NORM] |
			class1_i[fp_format_pkg::CLS_POS_SUB];
		b_zero = cls_b[fp_format_pkg::CLS_NEG_ZERO] | cls_b[fp_format_pkg::CLS_POS_ZERO];
		b_inf = cls_b[fp_format_pkg::CLS_NEG_INF] | cls_b[fp_format_pkg::CLS_POS_INF];
		b_finite_nz = cls_b[fp_format_pkg::CLS_NEG_NORM] | cls_b[fp_format_pkg::CLS_NEG_SUB] |
			cls_b[fp_format_pkg::CLS_POS_NORM] | cls_b[fp_format_pkg::CLS_POS_SUB];

		snan_d = class1_i[fp_format_pkg::CLS_SNAN] | cls_b[fp_format_pkg::CLS_SNAN] |
			(a_zero & b_zero) | (a_inf & b_inf);
		if (sqrt_i && (a_negative || class1_i[fp_format_pkg::CLS_NEG_INF])) begin
			snan_d = 1'b1; // Root of a negative number.
		end
		qnan_d = !snan_d && (class1_i[fp_format_pkg::CLS_QNAN] || cls_b[fp_format_pkg::CLS_QNAN]);
		inf_d = (a_inf & (b_finite_nz | b_zero)) | (sqrt_i & class1_i[fp_format_pkg::CLS_POS_INF]);
		dbz_d = !inf_d && b_zero && a_finite_nz;
		zero_d = a_zero | b_inf;
	end

	always_ff @(posedge clock_i) begin
		if (capture_i) begin
			sign_o <= data1_i[fp_format_pkg::SIGN_BIT] ^ op_b[fp_format_pkg::SIGN_BIT];
			exponent_diff_o <= exp_diff;
			fraction_a_o <= data1_i[fp_format_pkg::FRAC_WIDTH-1:0];
			fraction_b_o <= op_b[fp_format_pkg::FRAC_WIDTH-1:0];
			exp_a_lsb_o <= data1_i[fp_format_pkg::FRAC_WIDTH];
		end
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			op_sqrt_o <= 1'b0;
			fmt_o <= 1'b0;
			rm_o <= '0;
			snan_o <= 1'b0;
			qnan_o <= 1'b0;
			dbz_o <= 1'b0;
			inf_o <= 1'b0;
			zero_o <= 1'b0;
		end else if (capture_i) begin
			op_sqrt_o <= sqrt_i;
			fmt_o <= fmt_i;
			rm_o <= rm_i;
			snan_o <= snan_d;
			qnan_o <= qnan_d;
			dbz_o <= dbz_d;
			inf_o <= inf_d;
			zero_o <= zero_d;
		end
	end

endmodule

`default_nettype wire

//--- design/fdiv_top.sv
`timescale 1ns/1ps
`default_nettype none

module fdiv_top (
	input logic clock,
	input logic reset,
	input logic fdiv_i,
	input logic fsqrt_i,
	input fp_format_pkg::operand_t data1_i,
	input fp_format_pkg::operand_t data2_i,
	input fp_format_pkg::class_t class1_i,
	input fp_format_pkg::class_t class2_i,
	input logic fmt_i,
	input fp_format_pkg::rm_t rm_i,
	output logic sign_o,
	output fp_format_pkg::exponent_t exponent_o,
	output fp_format_pkg::mantissa_t mantissa_o,
	output fp_format_pkg::grs_t grs_o,
	output logic snan_o,
	output logic qnan_o,
	output logic dbz_o,
	output logic inf_o,
	output logic zero_o,
	output logic fmt_o,
	output fp_format_pkg::rm_t rm_o,
	output logic ready_o
);

	logic capture;
	logic load;
	logic sign_q;
	fp_format_pkg::exponent_t exponent_diff;
	logic [fp_format_pkg::FRAC_WIDTH-1:0] fraction_a;
	logic [fp_format_pkg::FRAC_WIDTH-1:0] fraction_b;
	logic exp_a_lsb;
	logic op_sqrt;
	fdiv_ctrl_pkg::quotient_t quotient;
	fdiv_ctrl_pkg::remainder_t remainder;

	//////////////////////////////
	fdiv_special_cases u_special_cases (
		.clock_i(clock),
		.reset_i(reset),
		.capture_i(capture),
		.sqrt_i(fsqrt_i), // Root wins if both strobes are set.
		.data1_i(data1_i),
		.data2_i(data2_i),
		.class1_i(class1_i),
		.class2_i(class2_i),
		.fmt_i(fmt_i),
		.rm_i(rm_i),
		.sign_o(sign_q),
		.exponent_diff_o(exponent_diff),
		.fraction_a_o(fraction_a),
		.fraction_b_o(fraction_b),
		.exp_a_lsb_o(exp_a_lsb),
		.op_sqrt_o(op_sqrt),
		.fmt_o(fmt_o),
		.rm_o(rm_o),
		.snan_o(snan_o),
		.qnan_o(qnan_o),
		.dbz_o(dbz_o),
		.inf_o(inf_o),
		.zero_o(zero_o)
	);

	fdiv_iterator u_iterator (
		.clock_i(clock),
		.reset_i(reset),
		.fdiv_i(fdiv_i),
		.fsqrt_i(fsqrt_i),
		.fmt_i(fmt_i),
		.fraction_a_i(fraction_a),
		.fraction_b_i(fraction_b),
		.exp_a_lsb_i(exp_a_lsb),
		.op_sqrt_i(op_sqrt),
		.capture_o(capture),
		.load_o(load),
		.ready_o(ready_o),
		.quotient_o(quotient),
		.remainder_o(remainder)
	);

	fdiv_normalizer u_normalizer (
		.clock_i(clock),
		.reset_i(reset),
		.load_i(load),
		.quotient_i(quotient),
		.remainder_i(remainder),
		.sign_i(sign_q),
		.exponent_diff_i(exponent_diff),
		.fmt_i(fmt_o),
		.sign_o(sign_o),
		.exponent_o(exponent_o),
		.mantissa_o(mantissa_o),
		.grs_o(grs_o)
	);

endmodule

`default_nettype wire

//--- design/fp_format_pkg.sv
`default_nettype none

package fp_format_pkg;

	//////////////////////////////
	// Recoded operand.
	//////////////////////////////

	localparam int OPERAND_WIDTH = 65;
	localparam int SIGN_BIT = 64;
	localparam int EXP_WIDTH = 12;
	localparam int FRAC_WIDTH = 52;
	localparam int CLASS_WIDTH = 10;

	typedef logic [OPERAND_WIDTH-1:0] operand_t;
	typedef logic [CLASS_WIDTH-1:0] class_t;

	// One-hot class vector bits.
	localparam int CLS_NEG_INF = 0;
	localparam int CLS_NEG_NORM = 1;
	localparam int CLS_NEG_SUB = 2;
	localparam int CLS_NEG_ZERO = 3;
	localparam int CLS_POS_ZERO = 4;
	localparam int CLS_POS_SUB = 5;
	localparam int CLS_POS_NORM = 6;
	localparam int CLS_POS_INF = 7;
	localparam int CLS_SNAN = 8;
	localparam int CLS_QNAN = 9;

	//////////////////////////////
	// Unrounded result.
	//////////////////////////////

	localparam int EXPONENT_WIDTH = 14;
	localparam int MANTISSA_WIDTH = 54;

	typedef logic signed [EXPONENT_WIDTH-1:0] exponent_t;
	typedef logic [MANTISSA_WIDTH-1:0] mantissa_t;
	typedef logic [2:0] grs_t;
	typedef logic [2:0] rm_t;

	localparam logic FMT_SINGLE = 1'b0;
	localparam logic FMT_DOUBLE = 1'b1;
	localparam int MANT_SINGLE_BITS = 24; // Hidden one included.
	localparam int MANT_DOUBLE_BITS = 53;

	localparam exponent_t BIAS_SINGLE = 14'sd127;
	localparam exponent_t BIAS_DOUBLE = 14'sd1023;
	localparam exponent_t SQRT_EXP_OFFSET = 14'sd2045;
	localparam exponent_t UNDERFLOW_SHIFT_MAX = 14'sd54;

	// Square root operand b is positive with exponent 7FF and a zero fraction.
	localparam operand_t SQRT_DIVISOR = 65'h0_7FF0_0000_0000_0000;

endpackage

`default_nettype wire

//--- sim.f
design/fp_format_pkg.sv
design/fdiv_ctrl_pkg.sv
design/fdiv_special_cases.sv
design/fdiv_iterator.sv
design/fdiv_normalizer.sv
design/fdiv_top.sv
tb/fdiv_properties.sv
tb/tb_fdiv.sv

//--- tb/fdiv_properties.sv
`timescale 1ns/1ps
`default_nettype none

module fdiv_properties (
	input logic clock_i,
	input logic reset_i,
	input logic capture_i,
	input logic fsqrt_i,
	input logic fmt_i,
	input logic ready_i,
	input logic snan_i,
	input logic qnan_i,
	input logic dbz_i,
	input logic inf_i,
	input logic zero_i,
	input fp_format_pkg::exponent_t exponent_i,
	input fp_format_pkg::mantissa_t mantissa_i
);

	logic [6:0] remaining; // Cycles left until the ready pulse.

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			remaining <= '0;
		end else if (capture_i) begin
			if (fsqrt_i) begin
				remaining <= (fmt_i == fp_format_pkg::FMT_SINGLE) ? 7'd27 : 7'd56;
			end else begin
				remaining <= (fmt_i == fp_format_pkg::FMT_SINGLE) ? 7'd28 : 7'd57;
			end
		end else if (remaining != 7'd0) begin
			remaining <= remaining - 7'd1;
		end
	end

	ready_latency: assert property (@(posedge clock_i) disable iff (reset_i)
		ready_i == (remaining == 7'd1))
		else $error("ready_o pulse does not match the request latency");

	ready_single_cycle: assert property (@(posedge clock_i) disable iff (reset_i)
		ready_i |=> !ready_i)
		else $error("ready_o high for two cycles in a row");

	reset_values: assert property (@(posedge clock_i)
		reset_i |=> (!ready_i && !snan_i && !qnan_i && !dbz_i && !inf_i && !zero_i &&
		exponent_i == '0 && mantissa_i == '0))
		else $error("outputs not cleared by reset");

	nan_exclusive: assert property (@(posedge clock_i) disable iff (reset_i)
		!(snan_i && qnan_i))
		else $error("snan_o and qnan_o both high");

	dbz_inf_exclusive: assert property (@(posedge clock_i) disable iff (reset_i)
		!(dbz_i && inf_i))
		else $error("dbz_o and inf_o both high");

endmodule

bind fdiv_top fdiv_properties u_properties (
	.clock_i(clock),
	.reset_i(reset),
	.capture_i(capture),
	.fsqrt_i(fsqrt_i),
	.fmt_i(fmt_i),
	.ready_i(ready_o),
	.snan_i(snan_o),
	.qnan_i(qnan_o),
	.dbz_i(dbz_o),
	.inf_i(inf_o),
	.zero_i(zero_o),
	.exponent_i(exponent_o),
	.mantissa_i(mantissa_o)
);

`default_nettype wire

//--- tb/tb_fdiv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fdiv;

	logic clock;
	logic reset;
	logic fdiv_i;
	logic fsqrt_i;
	fp_format_pkg::operand_t data1_i;
	fp_format_pkg::operand_t data2_i;
	fp_format_pkg::class_t class1_i;
	fp_format_pkg::class_t class2_i;
	logic fmt_i;
	fp_format_pkg::rm_t rm_i;
	logic sign_o;
	fp_format_pkg::exponent_t exponent_o;
	fp_format_pkg::mantissa_t mantissa_o;
	fp_format_pkg::grs_t grs_o;
	logic snan_o;
	logic qnan_o;
	logic dbz_o;
	logic inf_o;
	logic zero_o;
	logic fmt_o;
	fp_format_pkg::rm_t rm_o;
	logic ready_o;

	fdiv_top DUT (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	//////////////////////////////
	// Reference model.
	//////////////////////////////

	function automatic logic [127:0] int_sqrt(input logic [127:0] n);
		logic [127:0] r;
		logic [127:0] t;
		r = '0;
		for (int i = 63; i >= 0; i--) begin
			t = r | (128'b1 << i);
			if (t * t <= n) begin
				r = t;
			end
		end
		return r;
	endfunction

	task automatic compute_expected(input logic sqrt, input logic fmt, input logic [11:0] ea,
		input logic [11:0] eb, input logic [51:0] fa, input logic [51:0] fb,
		output logic [13:0] exp_e, output logic [53:0] mant_e, output logic [2:0] grs_e);
		logic [127:0] num;
		logic [127:0] den;
		logic [127:0] q;
		logic [127:0] ext;
		logic [127:0] mask;
		logic [54:0] qn;
		logic rem_nz;
		int e;
		int last;
		int mbits;
		int shift;
		last = (fmt == fp_format_pkg::FMT_SINGLE) ? 29 : 0;
		mbits = (fmt == fp_format_pkg::FMT_SINGLE) ? 24 : 53;
		if (sqrt) begin
			num = {75'b0, 1'b1, fa} << (ea[0] ? 54 : 55); // Even exponent doubles the radicand.
			q = (int_sqrt(num) >> last) << last;
			rem_nz = (num != q * q);
			e = (int'(ea) - 2045) >>> 1;
		end else begin
			num = {75'b0, 1'b1, fa} << 54;
			den = {75'b0, 1'b1, fb};
			q = ((num / den) >> last) << last;
			rem_nz = (num != q * den);
			e = int'(ea) - int'(eb);
		end
		qn = q[54:0];
		if (!qn[54]) begin
			qn = qn << 1;
			e = e - 1;
		end
		e = e + ((fmt == fp_format_pkg::FMT_SINGLE) ? 127 : 1023);
		shift = 0;
		if (e <= 0) begin
			shift = (1 - e > 54) ? 54 : 1 - e;
			e = 0;
		end
		ext = {qn, 73'b0} >> shift;
		mant_e = 54'(ext >> (128 - mbits));
		grs_e[2] = ext[127 - mbits];
		grs_e[1] = ext[126 - mbits];
		mask = (128'b1 << (126 - mbits)) - 128'b1;
		grs_e[0] = (|(ext & mask)) | rem_nz;
		exp_e = 14'(e);
	endtask

	// Returns {snan, qnan, dbz, inf, zero}.
	function automatic logic [4:0] expected_flags(input logic sqrt,
		input fp_format_pkg::class_t c1, input fp_format_pkg::class_t c2_in);
		fp_format_pkg::class_t c2;
		logic a_zero;
		logic a_inf;
		logic a_neg;
		logic a_fin;
		logic b_zero;
		logic b_inf;
		logic b_fin;
		logic snan;
		logic qnan;
		logic inf;
		logic dbz;
		c2 = sqrt ? '0 : c2_in;
		a_zero = c1[fp_format_pkg::CLS_NEG_ZERO] | c1[fp_format_pkg::CLS_POS_ZERO];
		a_inf = c1[fp_format_pkg::CLS_NEG_INF] | c1[fp_format_pkg::CLS_POS_INF];
		a_neg = c1[fp_format_pkg::CLS_NEG_NORM] | c1[fp_format_pkg::CLS_NEG_SUB];
		a_fin = a_neg | c1[fp_format_pkg::CLS_POS_NORM] | c1[fp_format_pkg::CLS_POS_SUB];
		b_zero = c2[fp_format_pkg::CLS_NEG_ZERO] | c2[fp_format_pkg::CLS_POS_ZERO];
		b_inf = c2[fp_format_pkg::CLS_NEG_INF] | c2[fp_format_pkg::CLS_POS_INF];
		b_fin = c2[fp_format_pkg::CLS_NEG_NORM] | c2[fp_format_pkg::CLS_NEG_SUB] |
			c2[fp_format_pkg::CLS_POS_NORM] | c2[fp_format_pkg::CLS_POS_SUB] | b_zero;
		snan = c1[fp_format_pkg::CLS_SNAN] | c2[fp_format_pkg::CLS_SNAN] | (a_zero & b_zero) |
			(a_inf & b_inf) | (sqrt & (a_neg | c1[fp_format_pkg::CLS_NEG_INF]));
		qnan = !snan & (c1[fp_format_pkg::CLS_QNAN] | c2[fp_format_pkg::CLS_QNAN]);
		inf = (a_inf & b_fin) | (sqrt & c1[fp_format_pkg::CLS_POS_INF]);
		dbz = !inf & b_zero & a_fin;
		return {snan, qnan, dbz, inf, a_zero | b_inf};
	endfunction

	//////////////////////////////
	// Drive and check.
	//////////////////////////////

	task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic wait_ready();
		int cycles = 0;
		do begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles > 100) begin
				$display("No ready_o pulse within 100 cycles of the request");
				$display("Test FAILED");
				$fatal(1);
			end
		end while (!ready_o);
	endtask

	task automatic issue(input logic sqrt, input logic fmt, input fp_format_pkg::operand_t a,
		input fp_format_pkg::operand_t b, input fp_format_pkg::class_t c1,
		input fp_format_pkg::class_t c2);
		@(posedge clock);
		#1;
		data1_i = a;
		data2_i = b;
		class1_i = c1;
		class2_i = c2;
		fmt_i = fmt;
		rm_i = 3'($urandom_range(4));
		fdiv_i = !sqrt;
		fsqrt_i = sqrt;
		@(posedge clock);
		#1;
		fdiv_i = 1'b0;
		fsqrt_i = 1'b0;
	endtask

	task automatic check_flags(input logic [4:0] exp);
		check_field("snan_o", snan_o, exp[4]);
		check_field("qnan_o", qnan_o, exp[3]);
		check_field("dbz_o", dbz_o, exp[2]);
		check_field("inf_o", inf_o, exp[1]);
		check_field("zero_o", zero_o, exp[0]);
	endtask

	task automatic run_arith(input logic sqrt, input logic fmt, input logic sa, input logic sb,
		input logic [11:0] ea, input logic [11:0] eb);
		logic [51:0] fa;
		logic [51:0] fb;
		logic [13:0] exp_e;
		logic [53:0] mant_e;
		logic [2:0] grs_e;
		fp_format_pkg::rm_t rm_sent;
		fa = 52'({$urandom(), $urandom()});
		fb = 52'({$urandom(), $urandom()});
		issue(sqrt, fmt, {sa, ea, fa}, {sb, eb, fb},
			10'(1) << (sa ? fp_format_pkg::CLS_NEG_NORM : fp_format_pkg::CLS_POS_NORM),
			10'(1) << (sb ? fp_format_pkg::CLS_NEG_NORM : fp_format_pkg::CLS_POS_NORM));
		rm_sent = rm_i;
		compute_expected(sqrt, fmt, ea, eb, fa, fb, exp_e, mant_e, grs_e);
		wait_ready();
		check_field("sign_o", sign_o, sqrt ? sa : sa ^ sb);
		check_field("exponent_o", {50'b0, exponent_o}, {50'b0, exp_e});
		check_field("mantissa_o", {10'b0, mantissa_o}, {10'b0, mant_e});
		check_field("grs_o", grs_o, grs_e);
		check_field("fmt_o", fmt_o, fmt);
		check_field("rm_o", rm_o, rm_sent);
		check_flags(5'b0);
	endtask

	task automatic run_special(input logic sqrt, input int cls_a, input int cls_b);
		fp_format_pkg::class_t c1;
		fp_format_pkg::class_t c2;
		c1 = 10'(1) << cls_a;
		c2 = 10'(1) << cls_b;
		issue(sqrt, fp_format_pkg::FMT_DOUBLE, 65'({$urandom(), $urandom(), $urandom()}),
			65'({$urandom(), $urandom(), $urandom()}), c1, c2);
		wait_ready();
		check_flags(expected_flags(sqrt, c1, c2));
	endtask

	initial begin
		void'($urandom(35548));
		reset = 1'b1;
		fdiv_i = 1'b0;
		fsqrt_i = 1'b0;
		data1_i = '0;
		data2_i = '0;
		class1_i = '0;
		class2_i = '0;
		fmt_i = fp_format_pkg::FMT_DOUBLE;
		rm_i = '0;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		repeat (5) @(posedge clock);

		for (int i = 0; i < 20; i++) begin
			run_arith(1'b0, fp_format_pkg::FMT_DOUBLE, 1'($urandom()), 1'($urandom()),
				12'(900 + $urandom_range(200)), 12'(900 + $urandom_range(200)));
			run_arith(1'b1, fp_format_pkg::FMT_DOUBLE, 1'b0, 1'b0,
				12'(1900 + $urandom_range(300)), 12'd0);
		end
		for (int i = 0; i < 10; i++) begin
			run_arith(1'b0, fp_format_pkg::FMT_SINGLE, 1'($urandom()), 1'($urandom()),
				12'(1000 + $urandom_range(60)), 12'(1000 + $urandom_range(60)));
			run_arith(1'b1, fp_format_pkg::FMT_SINGLE, 1'b0, 1'b0,
				12'(1900 + $urandom_range(300)), 12'd0);
		end
		// Underflow below and past the shift cap.
		for (int i = 0; i < 8; i++) begin
			run_arith(1'b0, fp_format_pkg::FMT_DOUBLE, 1'b0, 1'b1, 12'd100,
				12'(1124 + $urandom_range(60)));
			run_arith(1'b0, fp_format_pkg::FMT_SINGLE, 1'b1, 1'b0, 12'd100,
				12'(228 + $urandom_range(60)));
		end

		run_special(1'b1, fp_format_pkg::CLS_NEG_NORM, fp_format_pkg::CLS_POS_NORM);
		run_special(1'b1, fp_format_pkg::CLS_NEG_INF, fp_format_pkg::CLS_POS_NORM);
		run_special(1'b1, fp_format_pkg::CLS_POS_INF, fp_format_pkg::CLS_POS_NORM);
		run_special(1'b1, fp_format_pkg::CLS_POS_ZERO, fp_format_pkg::CLS_POS_ZERO);
		run_special(1'b0, fp_format_pkg::CLS_POS_ZERO, fp_format_pkg::CLS_NEG_ZERO);
		run_special(1'b0, fp_format_pkg::CLS_POS_INF, fp_format_pkg::CLS_NEG_INF);
		run_special(1'b0, fp_format_pkg::CLS_NEG_NORM, fp_format_pkg::CLS_POS_ZERO);
		run_special(1'b0, fp_format_pkg::CLS_NEG_INF, fp_format_pkg::CLS_POS_SUB);
		run_special(1'b0, fp_format_pkg::CLS_SNAN, fp_format_pkg::CLS_POS_NORM);
		run_special(1'b0, fp_format_pkg::CLS_QNAN, fp_format_pkg::CLS_POS_ZERO);
		run_special(1'b0, fp_format_pkg::CLS_POS_NORM, fp_format_pkg::CLS_QNAN);
		run_special(1'b0, fp_format_pkg::CLS_POS_SUB, fp_format_pkg::CLS_POS_INF);

		repeat (3) @(posedge clock);
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire
